// File: dcache.f
rtl/dcache_bus_pkg.sv
rtl/dcache_cfg_pkg.sv
rtl/cache_ctrl.sv
rtl/req_hold.sv
rtl/tag_store.sv
rtl/data_store.sv
rtl/mem_req_build.sv
rtl/dcache_top.sv
tests/mem_model.sv
tests/dcache_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the cache testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module dcache_tb -f dcache.f -o dcache_sim
./obj_dir/dcache_sim | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: tests/dcache_tb.sv
// testbench top for the data cache that applies a request table and checks it against shadow memory
`default_nettype none
`timescale 1ns/1ps

module dcache_tb import dcache_bus_pkg::*; ();

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 5;
    localparam int NUM_OPS        = 22;
    // edges after the accepting one
    localparam int HIT_LATENCY    = 1;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 40 + 100;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       req_valid;
    logic                       req_rw;
    logic [WORD_ADDR_WIDTH-1:0] req_addr;
    logic [WORD_SIZE-1:0]       req_byteen;
    logic [WORD_WIDTH-1:0]      req_data;
    logic [CORE_TAG_WIDTH-1:0]  req_tag;
    logic                       req_ready;
    logic                       rsp_valid;
    logic [WORD_WIDTH-1:0]      rsp_data;
    logic [CORE_TAG_WIDTH-1:0]  rsp_tag;
    logic                       mem_req_valid;
    logic                       mem_req_rw;
    logic [LINE_ADDR_WIDTH-1:0] mem_req_addr;
    logic [LINE_SIZE-1:0]       mem_req_byteen;
    logic [LINE_WIDTH-1:0]      mem_req_data;
    logic                       mem_req_ready;
    logic                       mem_rsp_valid;
    logic [LINE_WIDTH-1:0]      mem_rsp_data;
    int                         mem_count;

    // stimulus table
    logic        tbl_rw     [NUM_OPS];
    logic [15:0] tbl_addr   [NUM_OPS];
    logic [3:0]  tbl_be     [NUM_OPS];
    logic [31:0] tbl_data   [NUM_OPS];
    logic [3:0]  tbl_tag    [NUM_OPS];
    logic        tbl_mem_rd [NUM_OPS];
    int          table_len = 0;

    // shadow of memory words and of the direct-mapped tags
    logic [31:0] shadow_mem [int];
    logic [9:0]  shadow_tag [16];
    logic        shadow_valid [16];

    int          errors = 0;
    int          ops_passed = 0;
    int          ops_failed = 0;
    int          cycle_count = 0;
    logic        op_failed;

    always #(CLK_PERIOD / 2) clk = ~clk;

    dcache_top i_dut (.*);

    mem_model i_mem (
        .clk            (clk),
        .reset          (reset),
        .mem_req_valid  (mem_req_valid),
        .mem_req_rw     (mem_req_rw),
        .mem_req_addr   (mem_req_addr),
        .mem_req_byteen (mem_req_byteen),
        .mem_req_data   (mem_req_data),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data),
        .req_count      (mem_count)
    );

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [7:0] pattern_byte(input logic [17:0] byte_addr);
        return byte_addr[7:0] ^ byte_addr[15:8] ^ {6'b0, byte_addr[17:16]} ^ 8'h3c;
    endfunction

    // last written value or else the preset pattern
    function automatic logic [31:0] expected_word(input logic [15:0] addr);
        logic [31:0] w;
        if (shadow_mem.exists(int'(addr))) begin
            return shadow_mem[int'(addr)];
        end
        for (int b = 0; b < 4; b++) begin
            w[b*8 +: 8] = pattern_byte({addr, 2'(b)});
        end
        return w;
    endfunction

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp);
            errors    = errors + 1;
            op_failed = 1'b1;
        end
    endtask

    task automatic add_op(input logic rw, input logic [15:0] addr, input logic [3:0] be,
                          input logic [31:0] data, input logic [3:0] tag, input logic mem_rd);
        tbl_rw[table_len]     = rw;
        tbl_addr[table_len]   = addr;
        tbl_be[table_len]     = be;
        tbl_data[table_len]   = data;
        tbl_tag[table_len]    = tag;
        tbl_mem_rd[table_len] = mem_rd;
        table_len             = table_len + 1;
    endtask

    task automatic build_table;
        // read miss on index 4 then hits on the same line
        add_op(1'b0, 16'h0011, 4'hf, 32'h0, 4'h1, 1'b1);
        add_op(1'b0, 16'h0011, 4'hf, 32'h0, 4'h2, 1'b0);
        add_op(1'b0, 16'h0013, 4'hf, 32'h0, 4'h3, 1'b0);
        // write hit with the merged word read back from the array
        add_op(1'b1, 16'h0012, 4'h5, 32'hdeadbeef, 4'h4, 1'b0);
        add_op(1'b0, 16'h0012, 4'hf, 32'h0, 4'h5, 1'b0);
        // write miss without allocate
        add_op(1'b1, 16'h0128, 4'hc, 32'hcafef00d, 4'h6, 1'b0);
        add_op(1'b0, 16'h0128, 4'hf, 32'h0, 4'h7, 1'b1);
        add_op(1'b0, 16'h0129, 4'hf, 32'h0, 4'h8, 1'b0);
        // index 8 shared by tags 0x000 and 0x010
        add_op(1'b0, 16'h0020, 4'hf, 32'h0, 4'h9, 1'b1);
        add_op(1'b0, 16'h0420, 4'hf, 32'h0, 4'ha, 1'b1);
        add_op(1'b0, 16'h0020, 4'hf, 32'h0, 4'hb, 1'b1);
        add_op(1'b0, 16'h0420, 4'hf, 32'h0, 4'hc, 1'b1);
        // mixed tail
        add_op(1'b1, 16'h0421, 4'hf, 32'h12345678, 4'hd, 1'b0);
        add_op(1'b0, 16'h0421, 4'hf, 32'h0, 4'he, 1'b0);
        add_op(1'b0, 16'h0011, 4'hf, 32'h0, 4'hf, 1'b0);
        add_op(1'b1, 16'h0020, 4'h3, 32'ha5a55a5a, 4'h0, 1'b0);
        add_op(1'b0, 16'h0020, 4'hf, 32'h0, 4'h1, 1'b1);
        add_op(1'b0, 16'h0421, 4'hf, 32'h0, 4'h2, 1'b1);
        add_op(1'b0, 16'hffff, 4'hf, 32'h0, 4'h3, 1'b1);
        add_op(1'b1, 16'hfffc, 4'h8, 32'h77665544, 4'h4, 1'b0);
        add_op(1'b0, 16'hfffc, 4'hf, 32'h0, 4'h5, 1'b0);
        add_op(1'b0, 16'hffff, 4'hf, 32'h0, 4'h6, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////
    // one table entry through the DUT
    ////////////////////////////////////////////////////////////

    task automatic run_op(input int n);
        logic [3:0]  idx;
        logic [9:0]  ltag;
        logic        exp_hit;
        logic [31:0] exp_word;
        int          count_before;
        int          lat;
        idx          = tbl_addr[n][5:2];
        ltag         = tbl_addr[n][15:6];
        exp_hit      = shadow_valid[idx] && (shadow_tag[idx] == ltag);
        count_before = mem_count;
        op_failed    = 1'b0;
        req_rw       = tbl_rw[n];
        req_addr     = tbl_addr[n];
        req_byteen   = tbl_be[n];
        req_data     = tbl_data[n];
        req_tag      = tbl_tag[n];
        req_valid    = 1'b1;
        while (!req_ready) begin
            next_cycle();
        end
        // accepting edge
        next_cycle();
        req_valid = 1'b0;
        if (!tbl_rw[n]) begin
            lat = 0;
            while (!rsp_valid) begin
                next_cycle();
                lat = lat + 1;
            end
            exp_word = expected_word(tbl_addr[n]);
            check_value(rsp_data, exp_word, "read data");
            check_value(32'(rsp_tag), 32'(tbl_tag[n]), "response tag");
            // one line read per miss, none on a hit
            check_value(mem_count - count_before, 32'(tbl_mem_rd[n]), "memory reads");
            if (exp_hit) begin
                check_value(lat, HIT_LATENCY, "hit latency");
            end else begin
                // read miss allocates
                shadow_valid[idx] = 1'b1;
                shadow_tag[idx]   = ltag;
            end
        end else begin
            // write-through without a core response
            while (!req_ready) begin
                check_value(32'(rsp_valid), 32'h0, "write response strobe");
                next_cycle();
            end
            exp_word = expected_word(tbl_addr[n]);
            for (int b = 0; b < 4; b++) begin
                if (tbl_be[n][b]) begin
                    exp_word[b*8 +: 8] = tbl_data[n][b*8 +: 8];
                end
            end
            shadow_mem[int'(tbl_addr[n])] = exp_word;
            check_value(mem_count - count_before, 1, "memory writes");
        end
        if (op_failed) begin
            ops_failed = ops_failed + 1;
        end else begin
            ops_passed = ops_passed + 1;
        end
        $display("op %0d %s addr %h: %s", n, tbl_rw[n] ? "write" : "read", tbl_addr[n],
                 op_failed ? "failed" : "ok");
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and timeout
    ////////////////////////////////////////////////////////////

    initial begin
        reset      = 1'b1;
        req_valid  = 1'b0;
        req_rw     = 1'b0;
        req_addr   = '0;
        req_byteen = '0;
        req_data   = '0;
        req_tag    = '0;
        for (int i = 0; i < 16; i++) begin
            shadow_valid[i] = 1'b0;
            shadow_tag[i]   = '0;
        end
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int n = 0; n < NUM_OPS; n++) begin
            run_op(n);
        end
        $display("ops passed %0d, ops failed %0d, mismatches %0d", ops_passed, ops_failed,
                 errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("timeout: the table did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/mem_model.sv
// behavioral line memory for the cache testbench, random request stalls and fixed read latency
`default_nettype none
`timescale 1ns/1ps

module mem_model import dcache_bus_pkg::*; (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        mem_req_valid,
    input  wire                        mem_req_rw,
    input  wire  [LINE_ADDR_WIDTH-1:0] mem_req_addr,
    input  wire  [LINE_SIZE-1:0]       mem_req_byteen,
    input  wire  [LINE_WIDTH-1:0]      mem_req_data,
    output logic                       mem_req_ready,
    output logic                       mem_rsp_valid,
    output logic [LINE_WIDTH-1:0]      mem_rsp_data,
    output int                         req_count
);

    localparam int READ_LATENCY  = 3;
    localparam int NUM_MEM_LINES = 1 << LINE_ADDR_WIDTH;

    logic [LINE_WIDTH-1:0]      lines [NUM_MEM_LINES];
    integer                     seed = 32'h2a410e94;
    logic                       take;
    logic                       take_rw;
    logic [LINE_ADDR_WIDTH-1:0] take_addr;
    logic [LINE_SIZE-1:0]       take_byteen;
    logic [LINE_WIDTH-1:0]      take_data;
    int                         rsp_wait = 0;

    // every byte from its own 18-bit byte address
    function automatic logic [7:0] pattern_byte(input logic [17:0] byte_addr);
        return byte_addr[7:0] ^ byte_addr[15:8] ^ {6'b0, byte_addr[17:16]} ^ 8'h3c;
    endfunction

    initial begin
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        req_count     = 0;
        for (int l = 0; l < NUM_MEM_LINES; l++) begin
            for (int k = 0; k < LINE_SIZE; k++) begin
                lines[l][k*8 +: 8] = pattern_byte(18'(l * LINE_SIZE + k));
            end
        end
        forever begin
            ////////////////////////////////////////////////////////////
            // handshake sampled mid-cycle, both sides stable here
            ////////////////////////////////////////////////////////////
            @(negedge clk);
            take = ~reset & mem_req_valid & mem_req_ready;
            if (take) begin
                // counted once the handshake is certain
                req_count   = req_count + 1;
                take_rw     = mem_req_rw;
                take_addr   = mem_req_addr;
                take_byteen = mem_req_byteen;
                take_data   = mem_req_data;
            end
            @(posedge clk);
            #1;
            mem_rsp_valid = 1'b0;
            if (reset) begin
                rsp_wait  = 0;
                req_count = 0;
            end else if (take) begin
                if (take_rw) begin
                    for (int k = 0; k < LINE_SIZE; k++) begin
                        if (take_byteen[k]) begin
                            lines[take_addr][k*8 +: 8] = take_data[k*8 +: 8];
                        end
                    end
                end else begin
                    mem_rsp_data = lines[take_addr];
                    rsp_wait     = READ_LATENCY;
                end
            end
            // line strobed on the third edge after acceptance
            if (rsp_wait > 0) begin
                rsp_wait = rsp_wait - 1;
                if (rsp_wait == 0) begin
                    mem_rsp_valid = 1'b1;
                end
            end
            // ready about three cycles in four
            mem_req_ready = (($random(seed) & 3) != 0);
        end
    end

endmodule

`default_nettype wire

// File: rtl/dcache_top.sv
// data cache top level, one core port in front of a line-wide memory port
`default_nettype none
`timescale 1ns/1ps

module dcache_top import dcache_bus_pkg::*, dcache_cfg_pkg::*; (
    input  wire                        clk,
    input  wire                        reset,
    // core request
    input  wire                        req_valid,
    input  wire                        req_rw,
    input  wire [WORD_ADDR_WIDTH-1:0]  req_addr,
    input  wire [WORD_SIZE-1:0]        req_byteen,
    input  wire [WORD_WIDTH-1:0]       req_data,
    input  wire [CORE_TAG_WIDTH-1:0]   req_tag,
    output logic                       req_ready,
    // core response
    output logic                       rsp_valid,
    output logic [WORD_WIDTH-1:0]      rsp_data,
    output logic [CORE_TAG_WIDTH-1:0]  rsp_tag,
    // memory request
    output logic                       mem_req_valid,
    output logic                       mem_req_rw,
    output logic [LINE_ADDR_WIDTH-1:0] mem_req_addr,
    output logic [LINE_SIZE-1:0]       mem_req_byteen,
    output logic [LINE_WIDTH-1:0]      mem_req_data,
    input  wire                        mem_req_ready,
    // memory response
    input  wire                        mem_rsp_valid,
    input  wire  [LINE_WIDTH-1:0]      mem_rsp_data
);

    // controller strobes
    logic hold_load;
    logic read_en;
    logic write_en;
    logic fill_en;
    logic hit;

    // held request fields
    logic                       hold_rw;
    logic [INDEX_BITS-1:0]      hold_index;
    logic [TAG_BITS-1:0]        hold_line_tag;
    logic [WSEL_BITS-1:0]       hold_wsel;
    logic [LINE_ADDR_WIDTH-1:0] hold_line_addr;
    logic [WORD_SIZE-1:0]       hold_byteen;
    logic [WORD_WIDTH-1:0]      hold_data;

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    cache_ctrl i_cache_ctrl (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .hold_rw       (hold_rw),
        .hit           (hit),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .req_ready     (req_ready),
        .hold_load     (hold_load),
        .read_en       (read_en),
        .write_en      (write_en),
        .fill_en       (fill_en),
        .rsp_valid     (rsp_valid),
        .mem_req_valid (mem_req_valid)
    );

    ////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////

    req_hold i_req_hold (
        .clk            (clk),
        .hold_load      (hold_load),
        .req_rw         (req_rw),
        .req_addr       (req_addr),
        .req_byteen     (req_byteen),
        .req_data       (req_data),
        .req_tag        (req_tag),
        .hold_rw        (hold_rw),
        .hold_index     (hold_index),
        .hold_line_tag  (hold_line_tag),
        .hold_wsel      (hold_wsel),
        .hold_line_addr (hold_line_addr),
        .hold_byteen    (hold_byteen),
        .hold_data      (hold_data),
        .rsp_tag        (rsp_tag)
    );

    tag_store i_tag_store (
        .clk           (clk),
        .reset         (reset),
        .hold_index    (hold_index),
        .hold_line_tag (hold_line_tag),
        .fill_en       (fill_en),
        .hit           (hit)
    );

    data_store i_data_store (
        .clk          (clk),
        .hold_index   (hold_index),
        .hold_wsel    (hold_wsel),
        .hold_byteen  (hold_byteen),
        .hold_data    (hold_data),
        .read_en      (read_en),
        .write_en     (write_en),
        .fill_en      (fill_en),
        .mem_rsp_data (mem_rsp_data),
        .rsp_data     (rsp_data)
    );

    mem_req_build i_mem_req_build (
        .hold_rw        (hold_rw),
        .hold_line_addr (hold_line_addr),
        .hold_wsel      (hold_wsel),
        .hold_byteen    (hold_byteen),
        .hold_data      (hold_data),
        .mem_req_rw     (mem_req_rw),
        .mem_req_addr   (mem_req_addr),
        .mem_req_byteen (mem_req_byteen),
        .mem_req_data   (mem_req_data)
    );

endmodule

`default_nettype wire

// File: rtl/mem_req_build.sv
// builds the line-wide memory request fields from the held core request
`default_nettype none
`timescale 1ns/1ps

module mem_req_build import dcache_bus_pkg::*, dcache_cfg_pkg::*; (
    input  wire                        hold_rw,
    input  wire  [LINE_ADDR_WIDTH-1:0] hold_line_addr,
    input  wire  [WSEL_BITS-1:0]       hold_wsel,
    input  wire  [WORD_SIZE-1:0]       hold_byteen,
    input  wire  [WORD_WIDTH-1:0]      hold_data,
    output logic                       mem_req_rw,
    output logic [LINE_ADDR_WIDTH-1:0] mem_req_addr,
    output logic [LINE_SIZE-1:0]       mem_req_byteen,
    output logic [LINE_WIDTH-1:0]      mem_req_data
);

    logic [LINE_SIZE-1:0] wr_byteen;

    // word byte enable moved up to its slot in the line
    assign wr_byteen = {{(LINE_SIZE-WORD_SIZE){1'b0}}, hold_byteen} << (WORD_SIZE * hold_wsel);

    // reads fetch the full line
    assign mem_req_byteen = hold_rw ? wr_byteen : {LINE_SIZE{1'b1}};

    // same word in every slot, byte enable picks the one that counts
    assign mem_req_data = {WORDS_PER_LINE{hold_data}};

    assign mem_req_rw   = hold_rw;
    assign mem_req_addr = hold_line_addr;

endmodule

`default_nettype wire

// File: rtl/data_store.sv
// line data array: line fill, byte-merged write hit and registered word read
`default_nettype none
`timescale 1ns/1ps

module data_store import dcache_bus_pkg::*, dcache_cfg_pkg::*; (
    input  wire                   clk,
    input  wire  [INDEX_BITS-1:0] hold_index,
    input  wire  [WSEL_BITS-1:0]  hold_wsel,
    input  wire  [WORD_SIZE-1:0]  hold_byteen,
    input  wire  [WORD_WIDTH-1:0] hold_data,
    input  wire                   read_en,
    input  wire                   write_en,
    input  wire                   fill_en,
    input  wire  [LINE_WIDTH-1:0] mem_rsp_data,
    output logic [WORD_WIDTH-1:0] rsp_data
);

    // word 0 sits in the low bits of the memory line
    logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] line_mem [NUM_LINES];

    ////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////

    // fill and write hit never share a cycle
    // fill comes from fill_wait, write from lookup
    always_ff @(posedge clk) begin
        if (fill_en) begin
            line_mem[hold_index] <= mem_rsp_data;
        end else if (write_en) begin
            // only enabled bytes of the selected word
            for (int b = 0; b < WORD_SIZE; b++) begin
                if (hold_byteen[b]) begin
                    line_mem[hold_index][hold_wsel][b*8 +: 8] <= hold_data[b*8 +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////

    // registered at the end of a read hit lookup
    // holds its value until the next read hit
    always_ff @(posedge clk) begin
        if (read_en) begin
            rsp_data <= line_mem[hold_index][hold_wsel];
        end
    end

endmodule

`default_nettype wire

// File: rtl/tag_store.sv
// per-line tag and valid bit with hit compare, written on every line fill
`default_nettype none
`timescale 1ns/1ps

module tag_store import dcache_cfg_pkg::*; (
    input  wire                   clk,
    input  wire                   reset,
    input  wire  [INDEX_BITS-1:0] hold_index,
    input  wire  [TAG_BITS-1:0]   hold_line_tag,
    input  wire                   fill_en,
    output logic                  hit
);

    logic [TAG_BITS-1:0]  tag_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;

    ////////////////////////////////////////////////////////////
    // update
    ////////////////////////////////////////////////////////////

    // valid bits start cleared, set once a line is filled
    // no invalidate path since writes never allocate
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q[hold_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[hold_index] <= hold_line_tag;
        end
    end

    ////////////////////////////////////////////////////////////
    // compare
    ////////////////////////////////////////////////////////////

    // combinational from the held address
    // a replay after fill sees the new tag
    assign hit = valid_q[hold_index] & (tag_mem[hold_index] == hold_line_tag);

endmodule

`default_nettype wire

// File: rtl/req_hold.sv
// holds the accepted core request and splits its address for tags, data and memory
`default_nettype none
`timescale 1ns/1ps

module req_hold import dcache_bus_pkg::*, dcache_cfg_pkg::*; (
    input  wire                        clk,
    input  wire                        hold_load,
    input  wire                        req_rw,
    input  wire  [WORD_ADDR_WIDTH-1:0] req_addr,
    input  wire  [WORD_SIZE-1:0]       req_byteen,
    input  wire  [WORD_WIDTH-1:0]      req_data,
    input  wire  [CORE_TAG_WIDTH-1:0]  req_tag,
    output logic                       hold_rw,
    output logic [INDEX_BITS-1:0]      hold_index,
    output logic [TAG_BITS-1:0]        hold_line_tag,
    output logic [WSEL_BITS-1:0]       hold_wsel,
    output logic [LINE_ADDR_WIDTH-1:0] hold_line_addr,
    output logic [WORD_SIZE-1:0]       hold_byteen,
    output logic [WORD_WIDTH-1:0]      hold_data,
    output logic [CORE_TAG_WIDTH-1:0]  rsp_tag
);

    word_addr_u addr_q;

    // captured on the accepting edge, stable until the next one
    always_ff @(posedge clk) begin
        if (hold_load) begin
            hold_rw     <= req_rw;
            addr_q.raw  <= req_addr;
            hold_byteen <= req_byteen;
            hold_data   <= req_data;
            rsp_tag     <= req_tag;
        end
    end

    // cache view
    assign hold_line_tag  = addr_q.fields.tag;
    assign hold_index     = addr_q.fields.index;
    assign hold_wsel      = addr_q.fields.wsel;

    // memory view, word select dropped
    assign hold_line_addr = addr_q.raw[WORD_ADDR_WIDTH-1 -: LINE_ADDR_WIDTH];

endmodule

`default_nettype wire

// File: rtl/cache_ctrl.sv
// request FSM of the blocking cache: lookup, miss fill with replay, write-through
`default_nettype none
`timescale 1ns/1ps

module cache_ctrl (
    input  wire  clk,
    input  wire  reset,
    input  wire  req_valid,
    input  wire  hold_rw,
    input  wire  hit,
    input  wire  mem_req_ready,
    input  wire  mem_rsp_valid,
    output logic req_ready,
    output logic hold_load,
    output logic read_en,
    output logic write_en,
    output logic fill_en,
    output logic rsp_valid,
    output logic mem_req_valid
);

    // one-hot state flops, idle is none of them set
    logic lookup_q;
    logic mem_wait_q;
    logic fill_wait_q;
    logic respond_q;

    logic lookup_d;
    logic mem_wait_d;
    logic fill_wait_d;
    logic respond_d;

    logic idle_st;
    logic lookup_read_hit;
    logic lookup_to_mem;

    assign idle_st = ~(lookup_q | mem_wait_q | fill_wait_q | respond_q);

    ////////////////////////////////////////////////////////////
    // lookup decision
    ////////////////////////////////////////////////////////////

    // read hit answers from the array
    assign lookup_read_hit = lookup_q & hit & ~hold_rw;
    // every write goes out, a read only on a miss
    assign lookup_to_mem   = lookup_q & (hold_rw | ~hit);

    ////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////

    // new request, or replay once the line has landed
    assign lookup_d    = hold_load | fill_en;
    assign respond_d   = lookup_read_hit;
    // held until memory takes the request
    assign mem_wait_d  = lookup_to_mem | (mem_wait_q & ~mem_req_ready);
    // only reads wait for a line, writes drop back to idle
    assign fill_wait_d = (mem_wait_q & mem_req_ready & ~hold_rw)
                       | (fill_wait_q & ~mem_rsp_valid);

    always_ff @(posedge clk) begin
        if (reset) begin
            lookup_q    <= 1'b0;
            mem_wait_q  <= 1'b0;
            fill_wait_q <= 1'b0;
            respond_q   <= 1'b0;
        end else begin
            lookup_q    <= lookup_d;
            mem_wait_q  <= mem_wait_d;
            fill_wait_q <= fill_wait_d;
            respond_q   <= respond_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////

    // one request at a time
    assign req_ready     = idle_st;
    assign hold_load     = idle_st & req_valid;

    // word registered at the end of lookup
    assign read_en       = lookup_read_hit;
    // write hit updates the array, memory gets it anyway
    assign write_en      = lookup_q & hit & hold_rw;
    // line from memory goes to tags and data on the same edge
    assign fill_en       = fill_wait_q & mem_rsp_valid;

    // lines up with the registered read word
    assign rsp_valid     = respond_q;
    assign mem_req_valid = mem_wait_q;

endmodule

`default_nettype wire

// File: rtl/dcache_cfg_pkg.sv
// cache geometry and word address decode, imported by blocks that index lines
`default_nettype none

package dcache_cfg_pkg;

    import dcache_bus_pkg::*;

    ////////////////////////////////////////////////////////////
    // geometry
    ////////////////////////////////////////////////////////////

    // direct mapped, 16 lines of 4 words
    localparam int WORDS_PER_LINE = LINE_SIZE / WORD_SIZE;
    localparam int NUM_LINES      = 16;
    localparam int INDEX_BITS     = 4;
    // what remains of the line address after the index
    localparam int TAG_BITS       = LINE_ADDR_WIDTH - INDEX_BITS;

    ////////////////////////////////////////////////////////////
    // word address views
    ////////////////////////////////////////////////////////////

    // same word read two ways
    // raw is what goes out on the memory side (minus word select)
    // fields is what the tag and data arrays look at
    typedef union packed {
        logic [WORD_ADDR_WIDTH-1:0] raw;
        struct packed {
            logic [TAG_BITS-1:0]   tag;
            logic [INDEX_BITS-1:0] index;
            logic [WSEL_BITS-1:0]  wsel;
        } fields;
    } word_addr_u;

endpackage

`default_nettype wire

// File: rtl/dcache_bus_pkg.sv
// core and memory bus widths, imported by every block that carries bus signals
`default_nettype none

package dcache_bus_pkg;

    ////////////////////////////////////////////////////////////
    // core side
    ////////////////////////////////////////////////////////////

    // word address from the core
    localparam int WORD_ADDR_WIDTH = 16;
    // bytes and bits per word
    localparam int WORD_SIZE       = 4;
    localparam int WORD_WIDTH      = WORD_SIZE * 8;
    // request tag, returned with the read response
    localparam int CORE_TAG_WIDTH  = 4;
    // word select inside a line
    localparam int WSEL_BITS       = 2;

    ////////////////////////////////////////////////////////////
    // memory side
    ////////////////////////////////////////////////////////////

    // one memory beat is a whole line
    localparam int LINE_SIZE       = 16;
    localparam int LINE_WIDTH      = LINE_SIZE * 8;
    // line address is the word address with the word select removed
    localparam int LINE_ADDR_WIDTH = WORD_ADDR_WIDTH - WSEL_BITS;

endpackage

`default_nettype wire
